//--- MeasureFSM.sv
`timescale 1ns/10ps
`include "Sensor_macros.svh"

module MeasureFSM
  import SensorPkg::*;
(
  input  logic           Clk_i,
  input  logic           SensorFSM_TimerPreset,
  input  logic           Start_i,
  output measureResult_t Result_o,
  output logic           SensorRd_o,
  output logic           SensorAddr_o,
  input  logic           SensorValid_i,
  input  sensorByte_t    SensorData_i
);

  localparam int TimeoutWidth = $clog2(`MEASURE_TIMEOUT);
  localparam logic [TimeoutWidth-1:0] TimeoutLast = TimeoutWidth'(`MEASURE_TIMEOUT - 1);

  measureState_t           state;
  logic [TimeoutWidth-1:0] waitCount;
  logic                    timedOut;
  logic                    errorPulse;
  logic                    readPulse;
  logic                    readAddr;
  sensorByte_t             byte0;
  sensorByte_t             byte1;

  assign timedOut = (waitCount == TimeoutLast);

  always_ff @(posedge Clk_i)
  begin
    if (SensorFSM_TimerPreset)
    begin
      state      <= msIdle;
      waitCount  <= '0;
      errorPulse <= 1'b0;
      readPulse  <= 1'b0;
      readAddr   <= 1'b0;
    end
    else
    begin
      readPulse  <= 1'b0;
      errorPulse <= 1'b0;
      case (state)
        msIdle:
        begin
          if (Start_i)
          begin
            state     <= msReadLow;
            readPulse <= 1'b1;
            readAddr  <= 1'b0;
            waitCount <= '0;
          end
        end
        msReadLow:
        begin
          if (SensorValid_i)
          begin
            state     <= msReadHigh;
            readPulse <= 1'b1; // ask for the high byte right away
            readAddr  <= 1'b1;
            waitCount <= '0;
          end
          else if (timedOut)
          begin
            state      <= msIdle;
            errorPulse <= 1'b1;
          end
          else
          begin
            waitCount <= waitCount + 1'b1;
          end
        end
        msReadHigh:
        begin
          if (SensorValid_i)
          begin
            state <= msReport;
          end
          else if (timedOut)
          begin
            state      <= msIdle;
            errorPulse <= 1'b1;
          end
          else
          begin
            waitCount <= waitCount + 1'b1;
          end
        end
        default:
        begin
          state <= msIdle; // Report lasts a single cycle
        end
      endcase
    end
  end

  always_ff @(posedge Clk_i)
  begin
    if (state == msReadLow && SensorValid_i)
    begin
      byte0 <= SensorData_i;
    end
    if (state == msReadHigh && SensorValid_i)
    begin
      byte1 <= SensorData_i;
    end
  end

  assign Result_o.done  = (state == msReport);
  assign Result_o.error = errorPulse;
  assign Result_o.byte0 = byte0;
  assign Result_o.byte1 = byte1;
  assign SensorRd_o     = readPulse;
  assign SensorAddr_o   = readAddr;

endmodule

//--- SensorChecker.sv
`timescale 1ns/10ps

module SensorChecker
(
  input  logic Clk_i,
  input  logic SensorRd_i,
  input  logic Irq_i,
  output int   ReadCount_o,
  output int   FailCount_o
);

  int    readCount = 0;
  int    errorCount = 0;
  int    testsRun = 0;
  int    testsFailed = 0;
  string testName = "startup";
  bit    testOk = 1'b1;

  // every read request on the sensor port is counted
  always @(posedge Clk_i)
  begin
    if (SensorRd_i)
    begin
      readCount <= readCount + 1;
    end
  end

  assign ReadCount_o = readCount;
  assign FailCount_o = errorCount;

  task automatic startTest(input string name);
    testName = name;
    testOk   = 1'b1;
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
      errorCount++;
      testOk = 1'b0;
    end
  endtask

  task automatic checkIrq(input logic expected);
    checkValue("Irq_o", {31'b0, Irq_i}, {31'b0, expected});
  endtask

  task automatic checkNoReads(input int countBefore);
    checkValue("SensorRd_o pulse count", readCount, countBefore);
  endtask

  task automatic reportProblem(input string what);
    $display("problem in %s: %s", testName, what);
    errorCount++;
    testOk = 1'b0;
  endtask

  task automatic endTest();
    testsRun++;
    if (!testOk)
    begin
      testsFailed++;
    end
    $display("test %0d, %s: %s", testsRun, testName, testOk ? "ok" : "not ok");
  endtask

  task automatic printCounts();
    $display("%0d tests, %0d ok, %0d not ok, %0d failing checks",
             testsRun, testsRun - testsFailed, testsFailed, errorCount);
  endtask

endmodule

//--- SensorClockGen.sv
`timescale 1ns/10ps

module SensorClockGen
(
  output logic Clk_o,
  output logic Rst_o
);

  initial
  begin
    Clk_o = 1'b0;
    Rst_o = 1'b1;
    repeat (2) @(posedge Clk_o);
    @(negedge Clk_o);
    Rst_o = 1'b0; // released away from the active edge
  end

  always #50 Clk_o = ~Clk_o;

endmodule

//--- SensorFSM.sv
`timescale 1ns/10ps

module SensorFSM
  import SensorPkg::*;
(
  input  logic           Clk_i,
  input  logic           SensorFSM_TimerPreset,
  input  sensorParams_t  Params_i,
  input  measureResult_t Result_i,
  output logic           MeasureStart_o,
  output logic           CpuIntr_o,
  output sensorWord_t    SensorValue_o
);

  localparam int WordWidth = $bits(sensorWord_t);

  sensorState_t         state;
  sensorState_t         nextState;
  timerCount_t          timer;
  logic                 timerLoad;
  logic                 timerZero;
  logic                 storeValue;
  logic                 diffTooLarge;
  sensorWord_t          newValue;
  sensorWord_t          storedValue;
  sensorWord_t          absDiff;
  logic [WordWidth:0]   diffUp;
  sensorWord_t          diffDown;

  always_ff @(posedge Clk_i)
  begin
    if (SensorFSM_TimerPreset)
    begin
      state <= stDisabled;
    end
    else
    begin
      state <= nextState;
    end
  end

  always_comb
  begin
    nextState      = state;
    timerLoad      = 1'b1; // the timer sits at the period unless counting
    MeasureStart_o = 1'b0;
    storeValue     = 1'b0;
    CpuIntr_o      = 1'b0;
    case (state)
      stDisabled:
      begin
        if (Params_i.enable)
        begin
          nextState = stIdle;
        end
      end
      stIdle:
      begin
        timerLoad = 1'b0;
        if (!Params_i.enable)
        begin
          nextState = stDisabled;
        end
        else if (timerZero)
        begin
          nextState      = stXfer;
          MeasureStart_o = 1'b1;
        end
      end
      stXfer:
      begin
        if (Result_i.error)
        begin
          nextState = stError;
          CpuIntr_o = 1'b1; // the only interrupt until enable is cleared
        end
        else if (Result_i.done)
        begin
          if (diffTooLarge)
          begin
            nextState  = stNotify;
            storeValue = 1'b1;
          end
          else
          begin
            nextState = stIdle;
          end
        end
      end
      stNotify:
      begin
        nextState = stIdle;
        CpuIntr_o = 1'b1;
      end
      stError:
      begin
        if (!Params_i.enable)
        begin
          nextState = stDisabled;
        end
      end
      default:
      begin
        nextState = stDisabled;
      end
    endcase
  end

  always_ff @(posedge Clk_i)
  begin
    if (SensorFSM_TimerPreset)
    begin
      timer       <= '0;
      storedValue <= '0;
    end
    else
    begin
      if (timerLoad)
      begin
        timer <= {Params_i.periodHigh, Params_i.periodLow};
      end
      else
      begin
        timer <= timer - 1'b1;
      end
      if (storeValue)
      begin
        storedValue <= newValue;
      end
    end
  end

  assign timerZero = (timer == '0);
  assign newValue  = {Result_i.byte1, Result_i.byte0};

  // the borrow of the upward difference picks the direction of the unsigned distance
  assign diffUp       = {1'b0, newValue} - {1'b0, storedValue};
  assign diffDown     = storedValue - newValue;
  assign absDiff      = diffUp[WordWidth] ? diffDown : diffUp[WordWidth-1:0];
  assign diffTooLarge = (absDiff > Params_i.threshold);

  assign SensorValue_o = storedValue;

endmodule

//--- SensorPkg.sv
`include "Sensor_macros.svh"

package SensorPkg;

  typedef logic [`SENSOR_DATA_WIDTH-1:0]   sensorByte_t;
  typedef logic [2*`SENSOR_DATA_WIDTH-1:0] sensorWord_t;
  typedef logic [4*`SENSOR_DATA_WIDTH-1:0] timerCount_t;
  typedef logic [7:0]                      axiAddr_t;
  typedef logic [31:0]                     axiData_t;

  typedef enum logic [2:0] {
    stDisabled,
    stIdle,
    stXfer,
    stNotify,
    stError
  } sensorState_t;

  typedef enum logic [1:0] {
    msIdle,
    msReadLow,
    msReadHigh,
    msReport
  } measureState_t;

  typedef struct packed {
    logic        enable;
    sensorWord_t threshold;
    sensorWord_t periodHigh;
    sensorWord_t periodLow;
  } sensorParams_t;

  typedef struct packed {
    logic        done;
    logic        error;
    sensorByte_t byte0;
    sensorByte_t byte1;
  } measureResult_t;

  typedef struct packed {
    logic       awValid;
    axiAddr_t   awAddr;
    logic       wValid;
    axiData_t   wData;
    logic [3:0] wStrb;
    logic       bReady;
    logic       arValid;
    axiAddr_t   arAddr;
    logic       rReady;
  } axiLiteReq_t;

  typedef struct packed {
    logic       awReady;
    logic       wReady;
    logic       bValid;
    logic [1:0] bResp;
    logic       arReady;
    logic       rValid;
    axiData_t   rData;
    logic [1:0] rResp;
  } axiLiteRsp_t;

endpackage

//--- SensorRegs.sv
`timescale 1ns/10ps
`include "Sensor_macros.svh"

module SensorRegs
  import SensorPkg::*;
(
  input  logic          Clk_i,
  input  logic          SensorFSM_TimerPreset,
  input  axiLiteReq_t   AxiReq_i,
  output axiLiteRsp_t   AxiRsp_o,
  output sensorParams_t Params_o,
  input  logic          CpuIntr_i,
  input  sensorWord_t   SensorValue_i,
  output logic          Irq_o
);

  logic        busIdle;
  logic        awTaken;
  logic        wTaken;
  axiAddr_t    awAddrHeld;
  axiData_t    wDataHeld;
  logic [3:0]  wStrbHeld;
  logic        awFire;
  logic        wFire;
  logic        arFire;
  logic        writeNow;
  axiAddr_t    writeAddr;
  axiData_t    writeData;
  logic [3:0]  writeStrb;
  axiData_t    writeMerged;
  logic        bValid;
  logic [1:0]  bResp;
  logic        rValid;
  axiData_t    rData;
  logic [1:0]  rResp;
  logic        enableReg;
  sensorWord_t thresholdReg;
  timerCount_t periodReg;
  logic        irqStatus;

  function automatic logic isMapped(axiAddr_t addr);
    return addr == `REG_CTRL || addr == `REG_THRESHOLD || addr == `REG_PERIOD ||
           addr == `REG_VALUE || addr == `REG_IRQ_STATUS;
  endfunction

  function automatic axiData_t regValue(axiAddr_t addr);
    axiData_t value;
    case (addr)
      `REG_CTRL:       value = {31'b0, enableReg};
      `REG_THRESHOLD:  value = {16'b0, thresholdReg};
      `REG_PERIOD:     value = periodReg;
      `REG_VALUE:      value = {16'b0, SensorValue_i};
      `REG_IRQ_STATUS: value = {31'b0, irqStatus};
      default:         value = '0;
    endcase
    return value;
  endfunction

  // bytes without a strobe keep their old contents
  function automatic axiData_t mergeBytes(axiData_t oldValue, axiData_t newValue,
                                          logic [3:0] strb);
    axiData_t merged;
    merged = oldValue;
    for (int i = 0; i < 4; i++)
    begin
      if (strb[i])
      begin
        merged[8*i +: 8] = newValue[8*i +: 8];
      end
    end
    return merged;
  endfunction

  assign busIdle = !bValid && !rValid;

  always_comb
  begin
    AxiRsp_o.awReady = busIdle && !awTaken;
    AxiRsp_o.wReady  = busIdle && !wTaken;
    // a write in flight or on offer goes first
    AxiRsp_o.arReady = busIdle && !awTaken && !wTaken && !AxiReq_i.awValid && !AxiReq_i.wValid;
    AxiRsp_o.bValid  = bValid;
    AxiRsp_o.bResp   = bResp;
    AxiRsp_o.rValid  = rValid;
    AxiRsp_o.rData   = rData;
    AxiRsp_o.rResp   = rResp;
  end

  assign awFire      = AxiReq_i.awValid && AxiRsp_o.awReady;
  assign wFire       = AxiReq_i.wValid && AxiRsp_o.wReady;
  assign arFire      = AxiReq_i.arValid && AxiRsp_o.arReady;
  assign writeNow    = (awTaken || awFire) && (wTaken || wFire);
  assign writeAddr   = awTaken ? awAddrHeld : AxiReq_i.awAddr;
  assign writeData   = wTaken ? wDataHeld : AxiReq_i.wData;
  assign writeStrb   = wTaken ? wStrbHeld : AxiReq_i.wStrb;
  assign writeMerged = mergeBytes(regValue(writeAddr), writeData, writeStrb);

  always_ff @(posedge Clk_i)
  begin
    if (SensorFSM_TimerPreset)
    begin
      awTaken <= 1'b0;
      wTaken  <= 1'b0;
      bValid  <= 1'b0;
      bResp   <= `AXI_RESP_OKAY;
      rValid  <= 1'b0;
      rResp   <= `AXI_RESP_OKAY;
    end
    else
    begin
      if (writeNow)
      begin
        awTaken <= 1'b0;
        wTaken  <= 1'b0;
        bValid  <= 1'b1;
        bResp   <= isMapped(writeAddr) ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
      end
      else
      begin
        if (awFire)
        begin
          awTaken <= 1'b1;
        end
        if (wFire)
        begin
          wTaken <= 1'b1;
        end
        if (bValid && AxiReq_i.bReady)
        begin
          bValid <= 1'b0;
        end
      end
      if (arFire)
      begin
        rValid <= 1'b1;
        rResp  <= isMapped(AxiReq_i.arAddr) ? `AXI_RESP_OKAY : `AXI_RESP_SLVERR;
      end
      else if (rValid && AxiReq_i.rReady)
      begin
        rValid <= 1'b0;
      end
    end
  end

  always_ff @(posedge Clk_i)
  begin
    if (awFire)
    begin
      awAddrHeld <= AxiReq_i.awAddr;
    end
    if (wFire)
    begin
      wDataHeld <= AxiReq_i.wData;
      wStrbHeld <= AxiReq_i.wStrb;
    end
    if (arFire)
    begin
      rData <= regValue(AxiReq_i.arAddr); // zero for an unmapped offset
    end
  end

  always_ff @(posedge Clk_i)
  begin
    if (SensorFSM_TimerPreset)
    begin
      enableReg    <= 1'b0;
      thresholdReg <= '0;
      periodReg    <= '0;
      irqStatus    <= 1'b0;
    end
    else
    begin
      if (writeNow)
      begin
        case (writeAddr)
          `REG_CTRL:       enableReg    <= writeMerged[0];
          `REG_THRESHOLD:  thresholdReg <= writeMerged[15:0];
          `REG_PERIOD:     periodReg    <= writeMerged;
          `REG_IRQ_STATUS: irqStatus    <= irqStatus && !(writeData[0] && writeStrb[0]);
          default:         ; // value is read-only and other offsets answer with an error
        endcase
      end
      if (CpuIntr_i)
      begin
        irqStatus <= 1'b1; // a new event beats a clear in the same cycle
      end
    end
  end

  assign Params_o.enable     = enableReg;
  assign Params_o.threshold  = thresholdReg;
  assign Params_o.periodHigh = periodReg[31:16];
  assign Params_o.periodLow  = periodReg[15:0];
  assign Irq_o               = irqStatus;

endmodule

//--- SensorSubsystem.sv
`timescale 1ns/10ps

module SensorSubsystem
  import SensorPkg::*;
(
  input  logic        Clk_i,
  input  logic        SensorFSM_TimerPreset,
  input  axiLiteReq_t AxiReq_i,
  output axiLiteRsp_t AxiRsp_o,
  output logic        SensorRd_o,
  output logic        SensorAddr_o,
  input  logic        SensorValid_i,
  input  sensorByte_t SensorData_i,
  output logic        Irq_o
);

  sensorParams_t  params;
  measureResult_t result;
  logic           measureStart;
  logic           cpuIntr;
  sensorWord_t    sensorValue;

  SensorRegs i_SensorRegs (
    .Clk_i                 (Clk_i),
    .SensorFSM_TimerPreset (SensorFSM_TimerPreset),
    .AxiReq_i              (AxiReq_i),
    .AxiRsp_o              (AxiRsp_o),
    .Params_o              (params),
    .CpuIntr_i             (cpuIntr),
    .SensorValue_i         (sensorValue),
    .Irq_o                 (Irq_o)
  );

  SensorFSM i_SensorFSM (
    .Clk_i                 (Clk_i),
    .SensorFSM_TimerPreset (SensorFSM_TimerPreset),
    .Params_i              (params),
    .Result_i              (result),
    .MeasureStart_o        (measureStart),
    .CpuIntr_o             (cpuIntr),
    .SensorValue_o         (sensorValue)
  );

  // talks to the external sensor port
  MeasureFSM i_MeasureFSM (
    .Clk_i                 (Clk_i),
    .SensorFSM_TimerPreset (SensorFSM_TimerPreset),
    .Start_i               (measureStart),
    .Result_o              (result),
    .SensorRd_o            (SensorRd_o),
    .SensorAddr_o          (SensorAddr_o),
    .SensorValid_i         (SensorValid_i),
    .SensorData_i          (SensorData_i)
  );

endmodule

//--- SensorTb.sv
`timescale 1ns/10ps
`include "Sensor_macros.svh"

module SensorTb
  import SensorPkg::*;
();

  typedef struct packed {
    sensorWord_t value;
    logic        responds;
    logic        expectIrq;
    sensorWord_t expectValue;
  } sampleRow_t;

  localparam int          NumRows     = 7;
  localparam sensorWord_t Threshold   = 16'h0100;
  localparam timerCount_t Period      = 32'd200;
  localparam int          ReadTimeout = 2 * Period;
  localparam int          AxiTimeout  = 20;
  localparam int          IrqWindow   = 30; // sensor latency plus the FSM steps to the status bit

  logic        clk;
  logic        rst;
  axiLiteReq_t axiReq;
  axiLiteRsp_t axiRsp;
  logic        sensorRd;
  logic        sensorAddr;
  logic        sensorValid;
  sensorByte_t sensorData;
  logic        irq;
  int          readCount;
  int          failCount;
  sampleRow_t  rows [NumRows];
  sensorWord_t sensorValue;
  logic        sensorSilent;
  logic [31:0] rngState = 32'he494_6f64;

  SensorClockGen i_SensorClockGen (
    .Clk_o (clk),
    .Rst_o (rst)
  );

  SensorSubsystem i_SensorSubsystem (
    .Clk_i                 (clk),
    .SensorFSM_TimerPreset (rst),
    .AxiReq_i              (axiReq),
    .AxiRsp_o              (axiRsp),
    .SensorRd_o            (sensorRd),
    .SensorAddr_o          (sensorAddr),
    .SensorValid_i         (sensorValid),
    .SensorData_i          (sensorData),
    .Irq_o                 (irq)
  );

  SensorChecker i_SensorChecker (
    .Clk_i       (clk),
    .SensorRd_i  (sensorRd),
    .Irq_i       (irq),
    .ReadCount_o (readCount),
    .FailCount_o (failCount)
  );

  function automatic logic [31:0] nextRandom(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // the sensor model answers each read after 1 to 10 cycles unless told to stay silent
  initial
  begin : sensorModel
    int   delay;
    logic addr;
    sensorValid = 1'b0;
    sensorData  = '0;
    forever
    begin
      @(negedge clk);
      sensorValid = 1'b0;
      if (sensorRd && !sensorSilent)
      begin
        addr     = sensorAddr;
        rngState = nextRandom(rngState);
        delay    = 1 + int'(rngState % 32'd10);
        repeat (delay) @(negedge clk);
        sensorData  = addr ? sensorValue[15:8] : sensorValue[7:0];
        sensorValid = 1'b1;
      end
    end
  end

  // expected results follow the store and interrupt rule against the last stored value
  task automatic buildTable();
    sensorWord_t lastStored;
    int          diff;
    rows[0] = '{16'h1234, 1'b1, 1'b0, 16'h0000}; // far from zero with two different bytes
    rows[1] = '{16'h1300, 1'b1, 1'b0, 16'h0000};
    rows[2] = '{16'h1334, 1'b1, 1'b0, 16'h0000}; // difference equals the threshold
    rows[3] = '{16'h0F00, 1'b1, 1'b0, 16'h0000}; // large step downward
    rows[4] = '{16'h0FFF, 1'b1, 1'b0, 16'h0000};
    rows[5] = '{16'hABCD, 1'b0, 1'b0, 16'h0000}; // silent sensor
    rows[6] = '{16'h5A5A, 1'b1, 1'b0, 16'h0000};
    lastStored = '0;
    for (int i = 0; i < NumRows; i++)
    begin
      diff = int'(rows[i].value) - int'(lastStored);
      if (diff < 0)
      begin
        diff = -diff;
      end
      if (!rows[i].responds)
      begin
        rows[i].expectIrq = 1'b1;
      end
      else if (diff > int'(Threshold))
      begin
        rows[i].expectIrq = 1'b1;
        lastStored        = rows[i].value;
      end
      rows[i].expectValue = lastStored;
    end
  endtask

  task automatic axiWrite(input axiAddr_t addr, input axiData_t data, output logic [1:0] resp);
    int cycles;
    cycles = 0;
    @(negedge clk);
    axiReq.awValid = 1'b1;
    axiReq.awAddr  = addr;
    axiReq.wValid  = 1'b1;
    axiReq.wData   = data;
    axiReq.wStrb   = 4'hF;
    @(negedge clk);
    while (!axiRsp.bValid && cycles < AxiTimeout)
    begin
      @(negedge clk);
      cycles++;
    end
    axiReq.awValid = 1'b0;
    axiReq.wValid  = 1'b0;
    resp           = axiRsp.bResp;
    if (!axiRsp.bValid)
    begin
      i_SensorChecker.reportProblem("write got no B response within the timeout");
    end
    else
    begin
      axiReq.bReady = 1'b1;
      @(negedge clk);
      axiReq.bReady = 1'b0;
    end
  endtask

  task automatic axiRead(input axiAddr_t addr, output axiData_t data, output logic [1:0] resp);
    int cycles;
    cycles = 0;
    @(negedge clk);
    axiReq.arValid = 1'b1;
    axiReq.arAddr  = addr;
    @(negedge clk);
    while (!axiRsp.rValid && cycles < AxiTimeout)
    begin
      @(negedge clk);
      cycles++;
    end
    axiReq.arValid = 1'b0;
    data           = axiRsp.rData;
    resp           = axiRsp.rResp;
    if (!axiRsp.rValid)
    begin
      i_SensorChecker.reportProblem("read got no R response within the timeout");
    end
    else
    begin
      axiReq.rReady = 1'b1;
      @(negedge clk);
      axiReq.rReady = 1'b0;
    end
  endtask

  task automatic writeReg(input axiAddr_t addr, input axiData_t data, input logic [1:0] expResp);
    logic [1:0] resp;
    axiWrite(addr, data, resp);
    i_SensorChecker.checkValue("bResp", {30'b0, resp}, {30'b0, expResp});
  endtask

  task automatic readCheck(input string name, input axiAddr_t addr, input axiData_t expected,
                           input logic [1:0] expResp);
    axiData_t   data;
    logic [1:0] resp;
    axiRead(addr, data, resp);
    i_SensorChecker.checkValue(name, data, expected);
    i_SensorChecker.checkValue({name, " rResp"}, {30'b0, resp}, {30'b0, expResp});
  endtask

  task automatic waitForReset();
    int cycles;
    cycles = 0;
    while (rst && cycles < 10)
    begin
      @(negedge clk);
      cycles++;
    end
    if (rst)
    begin
      i_SensorChecker.reportProblem("reset was never released");
    end
  endtask

  task automatic waitForRead(input logic expectedAddr);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!sensorRd && cycles < ReadTimeout)
    begin
      @(negedge clk);
      cycles++;
    end
    if (sensorRd)
    begin
      i_SensorChecker.checkValue("SensorAddr_o", {31'b0, sensorAddr}, {31'b0, expectedAddr});
    end
    else
    begin
      i_SensorChecker.reportProblem("no sensor read request within the timeout");
    end
  endtask

  task automatic waitForIrq(input int maxCycles);
    int cycles;
    cycles = 0;
    while (!irq && cycles < maxCycles)
    begin
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic waitCycles(input int count);
    for (int i = 0; i < count; i++)
    begin
      @(negedge clk);
    end
  endtask

  task automatic runSample(input int i);
    int countBefore;
    i_SensorChecker.startTest($sformatf("sample %0d value 0x%h", i, rows[i].value));
    sensorValue  = rows[i].value;
    sensorSilent = !rows[i].responds;
    waitForRead(1'b0);
    if (rows[i].responds)
    begin
      waitForRead(1'b1);
    end
    waitForIrq(rows[i].responds ? IrqWindow : `MEASURE_TIMEOUT + IrqWindow);
    i_SensorChecker.checkIrq(rows[i].expectIrq);
    readCheck("IrqStatus", `REG_IRQ_STATUS, {31'b0, rows[i].expectIrq}, `AXI_RESP_OKAY);
    readCheck("Value", `REG_VALUE, {16'b0, rows[i].expectValue}, `AXI_RESP_OKAY);
    if (rows[i].expectIrq)
    begin
      writeReg(`REG_IRQ_STATUS, 32'h1, `AXI_RESP_OKAY);
      i_SensorChecker.checkIrq(1'b0);
    end
    if (!rows[i].responds)
    begin
      countBefore = readCount; // the error state must not sample again
      waitCycles(3 * Period);
      i_SensorChecker.checkNoReads(countBefore);
      writeReg(`REG_CTRL, 32'h0, `AXI_RESP_OKAY);
      writeReg(`REG_CTRL, 32'h1, `AXI_RESP_OKAY);
    end
    i_SensorChecker.endTest();
  endtask

  initial
  begin : mainSequence
    int countBefore;
    axiReq       = '0;
    sensorValue  = '0;
    sensorSilent = 1'b0;
    buildTable();
    waitForReset();

    i_SensorChecker.startTest("register access");
    writeReg(`REG_THRESHOLD, {16'b0, Threshold}, `AXI_RESP_OKAY);
    writeReg(`REG_PERIOD, Period, `AXI_RESP_OKAY);
    readCheck("Threshold", `REG_THRESHOLD, {16'b0, Threshold}, `AXI_RESP_OKAY);
    readCheck("Period", `REG_PERIOD, Period, `AXI_RESP_OKAY);
    writeReg(`REG_VALUE, 32'h0000_BEEF, `AXI_RESP_OKAY);
    readCheck("Value", `REG_VALUE, 32'h0, `AXI_RESP_OKAY); // nothing stored yet
    readCheck("unmapped offset", 8'h14, 32'h0, `AXI_RESP_SLVERR);
    i_SensorChecker.endTest();

    writeReg(`REG_CTRL, 32'h1, `AXI_RESP_OKAY);
    for (int i = 0; i < NumRows; i++)
    begin
      runSample(i);
    end

    i_SensorChecker.startTest("no reads while disabled");
    writeReg(`REG_CTRL, 32'h0, `AXI_RESP_OKAY);
    countBefore = readCount;
    waitCycles(4 * Period);
    i_SensorChecker.checkNoReads(countBefore);
    i_SensorChecker.endTest();

    i_SensorChecker.printCounts();
    if (failCount == 0)
    begin
      $display("Testbench passed");
    end
    else
    begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

//--- Sensor_macros.svh
`ifndef SENSOR_MACROS_SVH
`define SENSOR_MACROS_SVH

`define SENSOR_DATA_WIDTH 8

// register byte offsets on the AXI4-Lite bus
`define REG_CTRL       8'h00
`define REG_THRESHOLD  8'h04
`define REG_PERIOD     8'h08
`define REG_VALUE      8'h0C
`define REG_IRQ_STATUS 8'h10

`define MEASURE_TIMEOUT 64 // cycles to wait for each sensor byte

`define AXI_RESP_OKAY   2'b00
`define AXI_RESP_SLVERR 2'b10

`endif

//--- all.f
+incdir+.
SensorPkg.sv
SensorFSM.sv
MeasureFSM.sv
SensorRegs.sv
SensorSubsystem.sv
SensorClockGen.sv
SensorChecker.sv
SensorTb.sv

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module SensorTb -f all.f -o SensorTbSim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/SensorTbSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Testbench passed"; then
  exit 0
fi
exit 1
